// File: design/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

    // operand width of the engine, modulus and exponent alike
    localparam int RSA_WIDTH = 256;

    // top level sequencing
    // PREP maps the message into the Montgomery domain,
    // LOOP waits on both multipliers and UPDATE consumes one exponent bit
    typedef enum logic [1:0] {
        CORE_IDLE   = 2'd0,
        CORE_PREP   = 2'd1,
        CORE_LOOP   = 2'd2,
        CORE_UPDATE = 2'd3
    } core_state_t;

    // modular doubling engine
    typedef enum logic {
        PREP_IDLE = 1'b0,
        PREP_RUN  = 1'b1
    } prep_state_t;

    // bit-serial montgomery product
    // FIX is the single conditional subtraction at the end
    typedef enum logic [1:0] {
        MONT_IDLE = 2'd0,
        MONT_RUN  = 2'd1,
        MONT_FIX  = 2'd2
    } mont_state_t;

endpackage

`default_nettype wire

// File: design/rsa_modprod.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_modprod #(
    parameter int P_WIDTH = rsa_pkg::RSA_WIDTH
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_start,
    input  wire  [P_WIDTH-1:0]   i_mod,
    input  wire  [P_WIDTH-1:0]   i_base,
    output logic [P_WIDTH-1:0]   o_value,
    output logic                 o_done
);
    import rsa_pkg::*;

    localparam int CNT_W = $clog2(P_WIDTH);

    prep_state_t        state_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               done_q;
    logic [P_WIDTH-1:0] value_q;

    // doubled value needs one bit above the modulus
    logic [P_WIDTH:0]   dbl;
    logic [P_WIDTH:0]   dbl_red;

    assign o_value = value_q;
    assign o_done  = done_q;

    always_comb begin
        dbl = {value_q, 1'b0};
        if (dbl >= {1'b0, i_mod}) begin
            dbl_red = dbl - {1'b0, i_mod};
        end else begin
            dbl_red = dbl;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= PREP_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                PREP_IDLE: begin
                    if (i_start) begin
                        state_q <= PREP_RUN;
                        cnt_q   <= '0;
                    end
                end
                PREP_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    // last doubling happens on this edge
                    if (cnt_q == CNT_W'(P_WIDTH - 1)) begin
                        state_q <= PREP_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= PREP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == PREP_IDLE && i_start) begin
            value_q <= i_base;
        end else if (state_q == PREP_RUN) begin
            value_q <= dbl_red[P_WIDTH-1:0];
        end
    end

    // base below the modulus keeps every doubling reduced
    a_value_reduced: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (state_q == PREP_RUN) |-> (value_q < i_mod)
    ) else $error("rsa_modprod: value_q not below modulus");

endmodule

`default_nettype wire

// File: design/rsa_montmul.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_montmul #(
    parameter int P_WIDTH = rsa_pkg::RSA_WIDTH
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_start,
    input  wire  [P_WIDTH-1:0]   i_mod,
    input  wire  [P_WIDTH-1:0]   i_a,
    input  wire  [P_WIDTH-1:0]   i_b,
    output logic [P_WIDTH-1:0]   o_prod,
    output logic                 o_done
);
    import rsa_pkg::*;

    localparam int IDX_W = $clog2(P_WIDTH);

    mont_state_t        state_q;
    logic [IDX_W-1:0]   idx_q;
    logic               done_q;

    // two guard bits, partial sum reaches just under 4N
    logic [P_WIDTH+1:0] acc_q;
    logic [P_WIDTH+1:0] sum;
    logic [P_WIDTH+1:0] acc_step;
    logic [P_WIDTH+1:0] acc_fix;

    assign o_prod = acc_q[P_WIDTH-1:0];
    assign o_done = done_q;

    always_comb begin
        sum = acc_q;
        if (i_a[idx_q]) begin
            sum = sum + {2'b00, i_b};
        end
        // make it even so the shift divides exactly by two
        if (sum[0]) begin
            sum = sum + {2'b00, i_mod};
        end
        acc_step = sum >> 1;
    end

    always_comb begin
        if (acc_q >= {2'b00, i_mod}) begin
            acc_fix = acc_q - {2'b00, i_mod};
        end else begin
            acc_fix = acc_q;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= MONT_IDLE;
            idx_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                MONT_IDLE: begin
                    if (i_start) begin
                        state_q <= MONT_RUN;
                        idx_q   <= '0;
                    end
                end
                MONT_RUN: begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == IDX_W'(P_WIDTH - 1)) begin
                        state_q <= MONT_FIX;
                    end
                end
                MONT_FIX: begin
                    state_q <= MONT_IDLE;
                    done_q  <= 1'b1;
                end
                default: begin
                    state_q <= MONT_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state_q)
            MONT_IDLE: if (i_start) acc_q <= '0;
            MONT_RUN:  acc_q <= acc_step;
            MONT_FIX:  acc_q <= acc_fix;
            default:   acc_q <= acc_q;
        endcase
    end

    // needs i_b below the modulus, which the core keeps for m and t
    a_acc_bound: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (state_q == MONT_RUN) |=> (acc_q < {1'b0, i_mod, 1'b0})
    ) else $error("rsa_montmul: acc_q not below twice the modulus");

endmodule

`default_nettype wire

// File: design/rsa_core.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_core #(
    parameter int P_WIDTH = rsa_pkg::RSA_WIDTH
) (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_start,
    input  wire  [P_WIDTH-1:0]   i_msg,
    input  wire  [P_WIDTH-1:0]   i_exp,
    input  wire  [P_WIDTH-1:0]   i_mod,
    output logic [P_WIDTH-1:0]   o_result,
    output logic                 o_finished
);
    import rsa_pkg::*;

    localparam int IDX_W = $clog2(P_WIDTH);

    core_state_t        state_q;
    logic [IDX_W-1:0]   bit_q;
    logic               prep_start_q;
    logic               mul_start_q;
    logic               fin_q;
    logic [P_WIDTH-1:0] result_q;

    // latched operands
    logic [P_WIDTH-1:0] msg_q;
    logic [P_WIDTH-1:0] exp_q;
    logic [P_WIDTH-1:0] mod_q;

    // m stays an ordinary residue, t lives in the montgomery domain
    logic [P_WIDTH-1:0] m_q;
    logic [P_WIDTH-1:0] t_q;
    logic [P_WIDTH-1:0] m_next;

    logic [P_WIDTH-1:0] prep_value;
    logic               prep_done;
    logic [P_WIDTH-1:0] mul_prod;
    logic               mul_done;
    logic [P_WIDTH-1:0] sqr_prod;
    logic               sqr_done;

    assign o_result   = result_q;
    assign o_finished = fin_q;

    assign m_next = exp_q[bit_q] ? mul_prod : m_q;

    rsa_modprod #(
        .P_WIDTH (P_WIDTH)
    ) u_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start_q),
        .i_mod   (mod_q),
        .i_base  (msg_q),
        .o_value (prep_value),
        .o_done  (prep_done)
    );

    rsa_montmul #(
        .P_WIDTH (P_WIDTH)
    ) u_mul (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start_q),
        .i_mod   (mod_q),
        .i_a     (m_q),
        .i_b     (t_q),
        .o_prod  (mul_prod),
        .o_done  (mul_done)
    );

    rsa_montmul #(
        .P_WIDTH (P_WIDTH)
    ) u_sqr (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start_q),
        .i_mod   (mod_q),
        .i_a     (t_q),
        .i_b     (t_q),
        .o_prod  (sqr_prod),
        .o_done  (sqr_done)
    );

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q      <= CORE_IDLE;
            bit_q        <= '0;
            prep_start_q <= 1'b0;
            mul_start_q  <= 1'b0;
            fin_q        <= 1'b0;
            result_q     <= '0;
        end else begin
            prep_start_q <= 1'b0;
            mul_start_q  <= 1'b0;
            fin_q        <= 1'b0;
            case (state_q)
                CORE_IDLE: begin
                    if (i_start) begin
                        state_q      <= CORE_PREP;
                        prep_start_q <= 1'b1;
                        bit_q        <= '0;
                    end
                end
                CORE_PREP: begin
                    if (prep_done) begin
                        state_q     <= CORE_LOOP;
                        mul_start_q <= 1'b1;
                    end
                end
                CORE_LOOP: begin
                    if (mul_done && sqr_done) begin
                        state_q <= CORE_UPDATE;
                    end
                end
                CORE_UPDATE: begin
                    if (bit_q == IDX_W'(P_WIDTH - 1)) begin
                        state_q  <= CORE_IDLE;
                        fin_q    <= 1'b1;
                        result_q <= m_next;
                    end else begin
                        state_q     <= CORE_LOOP;
                        bit_q       <= bit_q + 1'b1;
                        mul_start_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= CORE_IDLE;
                end
            endcase
        end
    end

    // operands only move outside a multiplier run
    always_ff @(posedge i_clk) begin
        if (state_q == CORE_IDLE && i_start) begin
            msg_q <= i_msg;
            exp_q <= i_exp;
            mod_q <= i_mod;
        end
        if (state_q == CORE_PREP && prep_done) begin
            t_q <= prep_value;
            m_q <= P_WIDTH'(1);
        end
        if (state_q == CORE_UPDATE) begin
            m_q <= m_next;
            t_q <= sqr_prod;
        end
    end

    a_done_aligned: assert property (
        @(posedge i_clk) disable iff (i_rst)
        mul_done == sqr_done
    ) else $error("rsa_core: multiplier done pulses out of step");

    a_finished_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_finished |=> !o_finished
    ) else $error("rsa_core: o_finished held for two cycles");

endmodule

`default_nettype wire

// File: dv/rsa_tb_ref.svh
`ifndef RSA_TB_REF_SVH
`define RSA_TB_REF_SVH

// one step of the 32-bit xorshift sequence
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

task automatic rand_word(output logic [31:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state;
endtask

// operand built from W/32 words, first word ends up on top
task automatic rand_operand(output logic [W-1:0] v);
    logic [31:0] w;
    v = '0;
    for (int k = 0; k < W / 32; k++) begin
        rand_word(w);
        v = {v[W-33:0], w};
    end
endtask

// odd and full length
task automatic rand_modulus(output logic [W-1:0] n);
    rand_operand(n);
    n[W-1] = 1'b1;
    n[0]   = 1'b1;
endtask

task automatic rand_message(input logic [W-1:0] n, output logic [W-1:0] y);
    logic [W-1:0] r;
    rand_operand(r);
    y = r % n;
endtask

// plain right-to-left square and multiply, products kept at double width
function automatic logic [W-1:0] ref_modexp(input logic [W-1:0] base,
                                            input logic [W-1:0] e,
                                            input logic [W-1:0] n);
    logic [2*W-1:0] acc;
    logic [2*W-1:0] sq;
    logic [2*W-1:0] nn;
    nn  = {{W{1'b0}}, n};
    acc = (2*W)'(1) % nn;
    sq  = {{W{1'b0}}, base} % nn;
    for (int i = 0; i < W; i++) begin
        if (e[i]) begin
            acc = (acc * sq) % nn;
        end
        sq = (sq * sq) % nn;
    end
    return acc[W-1:0];
endfunction

`endif

// File: dv/rsa_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rsa_tb;
    import rsa_pkg::*;

    localparam int     W           = RSA_WIDTH;
    localparam int     CLK_HALF    = 4;
    localparam int     NUM_RUNS    = 16;
    // preparation plus one multiplier pass and update per exponent bit
    localparam longint RUN_BOUND   = (W + 1) + W * (W + 3);
    localparam longint WATCHDOG_NS = 2 * NUM_RUNS * RUN_BOUND * 2 * CLK_HALF;

    logic         clk;
    logic         rst;
    logic         start;
    logic [W-1:0] msg;
    logic [W-1:0] expo;
    logic [W-1:0] modulus;
    logic [W-1:0] result;
    logic         finished;

    logic [31:0]  rng_state;
    logic [W-1:0] expected_q;
    logic         seen_finish;
    int           start_count;
    int           finish_count;
    int           err_count;
    int           err_at_start;
    int           pass_count;
    int           fail_count;
    int           test_num;
    string        test_name;

    logic [W-1:0] n_a;
    logic [W-1:0] y_a;
    logic [W-1:0] e_a;
    logic [W-1:0] n_b;
    logic [W-1:0] y_b;
    logic [W-1:0] e_b;

    `include "rsa_tb_ref.svh"

    rsa_core #(
        .P_WIDTH (W)
    ) u_dut (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_start    (start),
        .i_msg      (msg),
        .i_exp      (expo),
        .i_mod      (modulus),
        .o_result   (result),
        .o_finished (finished)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, a run never reached o_finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            finish_count <= 0;
            seen_finish  <= 1'b0;
        end else if (finished) begin
            finish_count <= finish_count + 1;
            seen_finish  <= 1'b1;
        end
    end

    a_result: assert property (
        @(posedge clk) disable iff (rst)
        finished |-> (result == expected_q)
    ) else begin
        $display("ERROR: o_result = %h, expected %h", $sampled(result), $sampled(expected_q));
        err_count = err_count + 1;
    end

    // zero until the first completion
    a_idle_result: assert property (
        @(posedge clk) disable iff (rst)
        (!seen_finish && !finished) |-> (result == '0)
    ) else begin
        $display("ERROR: o_result = %h before first completion, expected %h",
                 $sampled(result), {W{1'b0}});
        err_count = err_count + 1;
    end

    a_finish_owed: assert property (
        @(posedge clk) disable iff (rst)
        finished |-> (finish_count < start_count)
    ) else begin
        $display("o_finished pulsed with no accepted start outstanding");
        err_count = err_count + 1;
    end

    task automatic begin_test(input string name);
        test_num     = test_num + 1;
        test_name    = name;
        err_at_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == err_at_start) begin
            pass_count = pass_count + 1;
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            fail_count = fail_count + 1;
            $display("test %0d %s: failed with %0d errors", test_num, test_name,
                     err_count - err_at_start);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic start_run(input logic [W-1:0] m, input logic [W-1:0] e,
                             input logic [W-1:0] n, input logic [W-1:0] want);
        msg         = m;
        expo        = e;
        modulus     = n;
        expected_q  = want;
        start       = 1'b1;
        start_count = start_count + 1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_run();
        while (finish_count != start_count) begin
            @(negedge clk);
        end
    endtask

    task automatic run_checked(input logic [W-1:0] m, input logic [W-1:0] e,
                               input logic [W-1:0] n, input logic [W-1:0] want);
        start_run(m, e, n, want);
        wait_run();
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        msg          = '0;
        expo         = '0;
        modulus      = '0;
        expected_q   = '0;
        rng_state    = 32'hac72197d;
        start_count  = 0;
        err_count    = 0;
        err_at_start = 0;
        pass_count   = 0;
        fail_count   = 0;
        test_num     = 0;
        test_name    = "";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset_idle");
        repeat (20) @(negedge clk);
        end_test();

        // x^0 is one, x^1 is x
        begin_test("exp_zero_one");
        rand_modulus(n_a);
        rand_message(n_a, y_a);
        run_checked(y_a, '0, n_a, W'(1));
        run_checked(y_a, W'(1), n_a, y_a);
        end_test();

        begin_test("random_modexp");
        repeat (10) begin
            rand_modulus(n_a);
            rand_message(n_a, y_a);
            rand_operand(e_a);
            run_checked(y_a, e_a, n_a, ref_modexp(y_a, e_a, n_a));
        end
        end_test();

        // (-1) to an odd power stays -1
        begin_test("all_ones_exp");
        rand_modulus(n_a);
        run_checked(n_a - W'(1), '1, n_a, n_a - W'(1));
        end_test();

        begin_test("start_while_busy");
        rand_modulus(n_a);
        rand_message(n_a, y_a);
        rand_operand(e_a);
        rand_modulus(n_b);
        rand_message(n_b, y_b);
        rand_operand(e_b);
        start_run(y_a, e_a, n_a, ref_modexp(y_a, e_a, n_a));
        repeat (10) @(negedge clk);
        msg     = y_b;
        expo    = e_b;
        modulus = n_b;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // again once the exponent loop is under way
        repeat (2 * W) @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_run();
        end_test();

        begin_test("back_to_back");
        rand_modulus(n_a);
        rand_message(n_a, y_a);
        rand_operand(e_a);
        rand_modulus(n_b);
        rand_message(n_b, y_b);
        rand_operand(e_b);
        run_checked(y_a, e_a, n_a, ref_modexp(y_a, e_a, n_a));
        run_checked(y_b, e_b, n_b, ref_modexp(y_b, e_b, n_b));
        end_test();

        repeat (4) @(negedge clk);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
design/rsa_pkg.sv
design/rsa_modprod.sv
design/rsa_montmul.sv
design/rsa_core.sv
dv/rsa_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the Verilator model of the testbench and run it
# exit status is zero only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rsa_tb -f src.f -o rsa_sim \
    > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rsa_sim > sim.log 2>&1

grep -qF "*** TEST PASSED ***" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
